/* rtl/rvIsaPkg.sv */
package rvIsaPkg;

   typedef logic [31:0] wordT;    // Data, address or instruction word
   typedef logic [4:0]  regIdxT;  // Register index, x0 to x31
   typedef logic [2:0]  funct3T;  // Operation subcode, instr[14:12]
   typedef logic [4:0]  opcodeT;  // Major opcode, instr[6:2]

   // ****************************************
   // Major opcodes (bits 1:0 always 2'b11 in RV32I)
   // ****************************************
   localparam opcodeT opLoad   = 5'b00000;  // rd <- mem[rs1 + immI]
   localparam opcodeT opAluImm = 5'b00100;  // rd <- rs1 op immI
   localparam opcodeT opAuipc  = 5'b00101;  // rd <- pc + immU
   localparam opcodeT opStore  = 5'b01000;  // mem[rs1 + immS] <- rs2
   localparam opcodeT opAluReg = 5'b01100;  // rd <- rs1 op rs2
   localparam opcodeT opLui    = 5'b01101;  // rd <- immU
   localparam opcodeT opBranch = 5'b11000;  // if (rs1 op rs2) pc <- pc + immB
   localparam opcodeT opJalr   = 5'b11001;  // rd <- pc + 4, pc <- rs1 + immI
   localparam opcodeT opJal    = 5'b11011;  // rd <- pc + 4, pc <- pc + immJ

   // ****************************************
   // Immediate formats, all sign extended from bit 31
   // ****************************************
   function automatic wordT immI(input wordT instr);
      return {{21{instr[31]}}, instr[30:20]};
   endfunction

   function automatic wordT immS(input wordT instr);
      return {{21{instr[31]}}, instr[30:25], instr[11:7]};
   endfunction

   function automatic wordT immB(input wordT instr);
      return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};  // Even offsets only
   endfunction

   function automatic wordT immU(input wordT instr);
      return {instr[31:12], 12'b0};
   endfunction

   function automatic wordT immJ(input wordT instr);
      return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   endfunction

endpackage

/* rtl/rvCorePkg.sv */
package rvCorePkg;

   // One flag per base instruction class, isAlu covers both ALU forms
   typedef struct packed {
      logic isLoad;
      logic isAluImm;
      logic isAuipc;
      logic isStore;
      logic isAluReg;
      logic isLui;
      logic isBranch;
      logic isJalr;
      logic isJal;
      logic isAlu;
   } opClassT;

   // One-hot FSM states
   typedef enum logic [7:0] {
      fetchInstr = 8'b0000_0001,  // Read strobe for the instruction
      waitInstr  = 8'b0000_0010,  // Instruction latched once rbusy drops
      fetchRegs  = 8'b0000_0100,  // Register reads in flight
      addrAndAlu = 8'b0000_1000,  // Address sum and ALU start
      execute    = 8'b0001_0000,  // Next pc, bus address, write-back
      load       = 8'b0010_0000,  // Read strobe for load data
      store      = 8'b0100_0000,  // Write mask on the bus
      waitMem    = 8'b1000_0000   // Hold until both busy levels are low
   } coreStateT;

   // Core to memory
   typedef struct packed {
      rvIsaPkg::wordT addr;
      rvIsaPkg::wordT wdata;
      logic [3:0]     wmask;  // Byte lanes, nonzero for one cycle per store
      logic           rstrb;  // One cycle read request
   } memReqT;

   // Memory to core
   typedef struct packed {
      rvIsaPkg::wordT rdata;
      logic           rbusy;
      logic           wbusy;
   } memRspT;

   // Instruction class from the major opcode
   function automatic opClassT decodeClass(input rvIsaPkg::wordT instr);
      opClassT         cls;
      rvIsaPkg::opcodeT op;
      op           = instr[6:2];
      cls.isLoad   = (op == rvIsaPkg::opLoad);
      cls.isAluImm = (op == rvIsaPkg::opAluImm);
      cls.isAuipc  = (op == rvIsaPkg::opAuipc);
      cls.isStore  = (op == rvIsaPkg::opStore);
      cls.isAluReg = (op == rvIsaPkg::opAluReg);
      cls.isLui    = (op == rvIsaPkg::opLui);
      cls.isBranch = (op == rvIsaPkg::opBranch);
      cls.isJalr   = (op == rvIsaPkg::opJalr);
      cls.isJal    = (op == rvIsaPkg::opJal);
      cls.isAlu    = cls.isAluImm | cls.isAluReg;
      return cls;
   endfunction

endpackage

/* rtl/rvAlu.sv */
module rvAlu (
   input  logic               clk,
   input  logic               start,      // One cycle, in addrAndAlu
   input  rvCorePkg::opClassT opClass,
   input  rvIsaPkg::wordT     instr,
   input  rvIsaPkg::wordT     rs1Data,
   input  rvIsaPkg::wordT     rs2Data,
   output rvIsaPkg::wordT     aluResult,  // Valid one cycle after start
   output logic               predicate   // Branch condition, same timing
);
   import rvIsaPkg::*;
   import rvCorePkg::*;

   funct3T             funct3;
   wordT               in2;        // Second operand
   wordT               plus;
   logic [32:0]        minus;      // rs1 - in2 with borrow in bit 32
   logic               isSub;
   logic               lt;
   logic               ltu;
   logic               eq;
   wordT               shiftIn;    // Bit reversed for left shifts
   logic signed [32:0] shiftFull;
   wordT               leftShift;

   // Bit reversal, lets one right shifter do both directions
   function automatic wordT flip(input wordT x);
      wordT y;
      for (int i = 0; i < 32; i++) begin
         y[i] = x[31 - i];
      end
      return y;
   endfunction

   assign funct3 = instr[14:12];
   assign in2    = opClass.isAluImm ? immI(instr) : rs2Data;  // Branches compare rs2
   assign isSub  = opClass.isAluReg & instr[30];               // Bit 30 belongs to immI for ADDI

   // ****************************************
   // Adder and the shared 33-bit subtractor
   // ****************************************
   assign plus  = rs1Data + in2;
   assign minus = {1'b1, ~in2} + {1'b0, rs1Data} + 33'd1;
   assign ltu   = minus[32];                                   // Borrow out
   assign lt    = (rs1Data[31] ^ in2[31]) ? rs1Data[31] : minus[32];
   assign eq    = (minus[31:0] == 32'd0);

   // Shifter, sign fill only for SRA/SRAI
   assign shiftIn   = funct3[2] ? rs1Data : flip(rs1Data);
   assign shiftFull = $signed({funct3[2] & instr[30] & rs1Data[31], shiftIn}) >>> in2[4:0];
   assign leftShift = flip(shiftFull[31:0]);

   // ALU result for register and immediate forms
   always_ff @(posedge clk) begin
      if (start && opClass.isAlu) begin
         case (funct3)
            3'b000:  aluResult <= isSub ? minus[31:0] : plus;  // ADD/SUB
            3'b001:  aluResult <= leftShift;                   // SLL
            3'b010:  aluResult <= {31'b0, lt};                 // SLT
            3'b011:  aluResult <= {31'b0, ltu};                // SLTU
            3'b100:  aluResult <= rs1Data ^ in2;               // XOR
            3'b101:  aluResult <= shiftFull[31:0];             // SRL/SRA
            3'b110:  aluResult <= rs1Data | in2;               // OR
            default: aluResult <= rs1Data & in2;               // AND
         endcase
      end
   end

   // Latched branch predicate
   always_ff @(posedge clk) begin
      if (start && opClass.isBranch) begin
         case (funct3)
            3'b000:  predicate <= eq;    // BEQ
            3'b001:  predicate <= !eq;   // BNE
            3'b100:  predicate <= lt;    // BLT
            3'b101:  predicate <= !lt;   // BGE
            3'b110:  predicate <= ltu;   // BLTU
            3'b111:  predicate <= !ltu;  // BGEU
            default: predicate <= 1'b0;  // Reserved encodings never taken
         endcase
      end
   end

endmodule

/* rtl/rvAddrUnit.sv */
module rvAddrUnit #(
   parameter int addrWidth = 24
) (
   input  logic               clk,
   input  logic               start,      // Registers addrSum
   input  rvCorePkg::opClassT opClass,
   input  rvIsaPkg::wordT     instr,
   input  rvIsaPkg::wordT     pc,
   input  rvIsaPkg::wordT     rs1Data,
   input  rvIsaPkg::wordT     rs2Data,
   input  rvIsaPkg::wordT     busAddr,    // Selects the byte lanes
   input  rvIsaPkg::wordT     rdata,
   output rvIsaPkg::wordT     addrSum,
   output rvIsaPkg::wordT     loadData,
   output rvIsaPkg::wordT     storeData,
   output logic [3:0]         storeMask
);
   import rvIsaPkg::*;
   import rvCorePkg::*;

   funct3T               funct3;
   logic                 byteAccess;
   logic                 halfAccess;
   wordT                 base;
   wordT                 offset;
   wordT                 sum;
   logic [addrWidth-1:0] sumNarrow;  // Address bits only
   logic [15:0]          loadHalf;
   logic [7:0]           loadByte;
   logic                 loadSign;

   assign funct3     = instr[14:12];
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // ****************************************
   // Address adder, pc + imm or rs1 + imm
   // ****************************************
   assign base   = (opClass.isLoad | opClass.isStore | opClass.isJalr) ? rs1Data : pc;
   assign offset = opClass.isJal    ? immJ(instr) :
                   opClass.isAuipc  ? immU(instr) :
                   opClass.isStore  ? immS(instr) :
                   opClass.isBranch ? immB(instr) :
                                      immI(instr);    // Load and JALR
   assign sum    = base + offset;
   // JALR target has bit 0 cleared
   assign sumNarrow = {sum[addrWidth-1:1], sum[0] & ~opClass.isJalr};

   always_ff @(posedge clk) begin
      if (start) begin
         addrSum <= opClass.isAuipc ? sum : wordT'(sumNarrow);  // AUIPC keeps all 32 bits
      end
   end

   // ****************************************
   // Load alignment and extension
   // ****************************************
   assign loadHalf = busAddr[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = busAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = ~funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);  // LBU/LHU zero fill
   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

   // Store data replicated into every lane it may land in
   assign storeData[7:0]   = rs2Data[7:0];
   assign storeData[15:8]  = busAddr[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign storeData[23:16] = busAddr[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign storeData[31:24] = busAddr[0] ? rs2Data[7:0] :
                             busAddr[1] ? rs2Data[15:8] : rs2Data[31:24];

   // Lane mask: one byte, a halfword pair or the whole word
   assign storeMask = byteAccess ? (4'b0001 << busAddr[1:0]) :
                      halfAccess ? (busAddr[1] ? 4'b1100 : 4'b0011) :
                                   4'b1111;

endmodule

/* rtl/rvRegFile.sv */
module rvRegFile (
   input  logic             clk,
   input  logic             we,
   input  rvIsaPkg::regIdxT rd,
   input  rvIsaPkg::wordT   wdata,
   input  logic             readEn,   // From waitInstr, data valid next cycle
   input  rvIsaPkg::regIdxT rs1Idx,
   input  rvIsaPkg::regIdxT rs2Idx,
   output rvIsaPkg::wordT   rs1Data,
   output rvIsaPkg::wordT   rs2Data
);
   import rvIsaPkg::*;

   wordT regs [32];  // Entry 0 never written

   // Write port, x0 discarded
   always_ff @(posedge clk) begin
      if (we && rd != 5'd0) begin
         regs[rd] <= wdata;
      end
   end

   // Registered two-port read
   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1Data <= (rs1Idx == 5'd0) ? 32'd0 : regs[rs1Idx];  // x0 reads zero
         rs2Data <= (rs2Idx == 5'd0) ? 32'd0 : regs[rs2Idx];
      end
   end

endmodule

/* rtl/rvControl.sv */
module rvControl #(
   parameter rvIsaPkg::wordT resetAddr = 32'd0,
   parameter int             addrWidth = 24
) (
   input  logic               clk,
   input  logic               reset,
   input  rvCorePkg::memRspT  memRsp,
   output rvCorePkg::memReqT  memReq,
   input  rvIsaPkg::wordT     aluResult,
   input  logic               predicate,
   input  rvIsaPkg::wordT     addrSum,
   input  rvIsaPkg::wordT     loadData,
   input  rvIsaPkg::wordT     storeData,
   input  logic [3:0]         storeMask,
   output rvIsaPkg::wordT     instr,
   output rvCorePkg::opClassT opClass,
   output rvIsaPkg::wordT     pc,
   output rvIsaPkg::wordT     busAddr,
   output logic               aluStart,
   output logic               regWe,
   output rvIsaPkg::regIdxT   regRd,
   output rvIsaPkg::wordT     regWdata,
   output logic               regReadEn,
   output rvIsaPkg::regIdxT   rs1Idx,
   output rvIsaPkg::regIdxT   rs2Idx
);
   import rvIsaPkg::*;
   import rvCorePkg::*;

   coreStateT            state;
   logic [addrWidth-1:0] pcReg;    // Program counter
   logic [addrWidth-1:0] addrReg;  // Drives the bus address
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] target;   // Jump, branch or data address
   logic                 jump;
   logic                 memIdle;

   assign pc      = wordT'(pcReg);    // Upper bits zero
   assign busAddr = wordT'(addrReg);
   assign pcPlus4 = pcReg + addrWidth'(4);
   assign target  = addrSum[addrWidth-1:0];
   assign jump    = opClass.isJal | opClass.isJalr | (opClass.isBranch & predicate);
   assign memIdle = ~memRsp.rbusy & ~memRsp.wbusy;

   // ****************************************
   // Bus strobes, decoded from state
   // ****************************************
   assign memReq.addr  = busAddr;
   assign memReq.wdata = storeData;
   assign memReq.wmask = (state == store) ? storeMask : 4'b0000;
   assign memReq.rstrb = (state == fetchInstr) | (state == load);

   assign aluStart  = (state == addrAndAlu);
   assign regReadEn = (state == waitInstr) & ~memRsp.rbusy;  // Same cycle instr is latched
   assign rs1Idx    = memRsp.rdata[19:15];                    // Fields of the incoming word
   assign rs2Idx    = memRsp.rdata[24:20];
   assign regRd     = instr[11:7];

   // Write-back in execute, or for loads on leaving waitMem
   assign regWe = ((state == execute) &
                   ~(opClass.isBranch | opClass.isStore | opClass.isLoad)) |
                  ((state == waitMem) & opClass.isLoad & memIdle);

   assign regWdata = opClass.isLui                   ? immU(instr)     :
                     opClass.isAlu                   ? aluResult       :
                     opClass.isAuipc                 ? addrSum         :
                     (opClass.isJal | opClass.isJalr) ? wordT'(pcPlus4) :  // Link address
                                                       loadData;

   // ****************************************
   // FSM, pc and decoded class
   // ****************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state   <= waitMem;  // Leaves once both busy levels are low
         pcReg   <= resetAddr[addrWidth-1:0];
         opClass <= '0;       // No pending load write-back
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRsp.rbusy) begin
                  opClass <= decodeClass(memRsp.rdata);
                  state   <= fetchRegs;
               end
            end
            fetchRegs:  state <= addrAndAlu;
            addrAndAlu: state <= execute;
            execute: begin
               pcReg <= jump ? target : pcPlus4;
               state <= opClass.isLoad  ? load  :
                        opClass.isStore ? store : fetchInstr;
            end
            waitMem: begin
               if (memIdle) begin
                  state <= fetchInstr;
               end
            end
            default:    state <= waitMem;  // Load and store
         endcase
      end
   end

   // Instruction latch and bus address
   always_ff @(posedge clk) begin
      if (state == waitInstr && !memRsp.rbusy) begin
         instr <= memRsp.rdata;
      end
      if (state == execute) begin
         addrReg <= (opClass.isLoad | opClass.isStore | jump) ? target : pcPlus4;
      end else if (state == waitMem && memIdle) begin
         addrReg <= pcReg;  // Back to the fetch address
      end
   end

endmodule

/* rtl/rvCore.sv */
module rvCore #(
   parameter rvIsaPkg::wordT resetAddr = 32'd0,
   parameter int             addrWidth = 24
) (
   input  logic              clk,
   input  logic              reset,
   output rvCorePkg::memReqT memReq,
   input  rvCorePkg::memRspT memRsp
);
   import rvIsaPkg::*;
   import rvCorePkg::*;

   // Decoded instruction and fetch state
   wordT    instr;
   opClassT opClass;
   wordT    pc;
   wordT    busAddr;
   logic    aluStart;

   // Unit results
   wordT       aluResult;
   logic       predicate;
   wordT       addrSum;
   wordT       loadData;
   wordT       storeData;
   logic [3:0] storeMask;

   // Register file ports
   logic   regWe;
   regIdxT regRd;
   wordT   regWdata;
   logic   regReadEn;
   regIdxT rs1Idx;
   regIdxT rs2Idx;
   wordT   rs1Data;
   wordT   rs2Data;

   rvControl #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) control_inst (
      .clk       (clk),
      .reset     (reset),
      .memRsp    (memRsp),
      .memReq    (memReq),
      .aluResult (aluResult),
      .predicate (predicate),
      .addrSum   (addrSum),
      .loadData  (loadData),
      .storeData (storeData),
      .storeMask (storeMask),
      .instr     (instr),
      .opClass   (opClass),
      .pc        (pc),
      .busAddr   (busAddr),
      .aluStart  (aluStart),
      .regWe     (regWe),
      .regRd     (regRd),
      .regWdata  (regWdata),
      .regReadEn (regReadEn),
      .rs1Idx    (rs1Idx),
      .rs2Idx    (rs2Idx)
   );

   // ALU and address unit both start in addrAndAlu
   rvAlu alu_inst (
      .clk       (clk),
      .start     (aluStart),
      .opClass   (opClass),
      .instr     (instr),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .aluResult (aluResult),
      .predicate (predicate)
   );

   rvAddrUnit #(
      .addrWidth (addrWidth)
   ) addrUnit_inst (
      .clk       (clk),
      .start     (aluStart),
      .opClass   (opClass),
      .instr     (instr),
      .pc        (pc),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .busAddr   (busAddr),
      .rdata     (memRsp.rdata),
      .addrSum   (addrSum),
      .loadData  (loadData),
      .storeData (storeData),
      .storeMask (storeMask)
   );

   rvRegFile regFile_inst (
      .clk     (clk),
      .we      (regWe),
      .rd      (regRd),
      .wdata   (regWdata),
      .readEn  (regReadEn),
      .rs1Idx  (rs1Idx),
      .rs2Idx  (rs2Idx),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data)
   );

endmodule

/* testbench/rvCore_checker.sv */
module rvCore_checker (
   input logic              clk,
   input logic              reset,
   input rvCorePkg::memReqT memReq
);
   timeunit 1ns;
   timeprecision 1ps;

   int violations = 0;  // Count of broken bus rules

   // ****************************************
   // Bus strobe rules
   // ****************************************
   // Read strobe and write mask are never on the bus together
   noReadWithWrite: assert property (@(posedge clk) disable iff (!reset)
      !(memReq.rstrb && memReq.wmask != 4'b0000))
      else begin
         $error("rstrb and wmask active in the same cycle");
         violations++;
      end

   // Byte lane, halfword pair or whole word only
   legalMask: assert property (@(posedge clk) disable iff (!reset)
      memReq.wmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                           4'b0011, 4'b1100, 4'b1111})
      else begin
         $error("illegal write mask %b", memReq.wmask);
         violations++;
      end

   // Bus quiet in the cycle after reset
   quietAfterReset: assert property (@(posedge clk)
      !reset |=> (!memReq.rstrb && memReq.wmask == 4'b0000))
      else begin
         $error("bus strobe active right after reset");
         violations++;
      end

endmodule

bind rvCore rvCore_checker checker_inst (
   .clk    (clk),
   .reset  (reset),
   .memReq (memReq)
);

/* testbench/rvCoreTb.sv */
module rvCoreTb;
   timeunit 1ns;
   timeprecision 1ps;
   import rvIsaPkg::*;
   import rvCorePkg::*;

   localparam int   clkPeriod = 10;
   localparam int   memDepth  = 256;            // Words, 1 KB
   localparam wordT endAddr   = 32'h0000_01fc;  // Program signals its end here
   localparam int   seed      = 32'h0960_9a2b;

   logic   clk = 1'b0;
   logic   reset;
   memReqT memReq;
   memRspT memRsp;
   memReqT reqSeen;  // Bus request sampled mid-cycle

   wordT       image [memDepth];  // Program image from the stimulus file
   wordT       mem   [memDepth];
   wordT       expAddr [$];
   wordT       expData [$];
   logic [3:0] expMask [$];
   int         numP;
   int         expIdx;
   int         errors;
   int         rCnt;
   int         wCnt;
   bit         stretchOn;
   bit         endSeen;
   bit         stimLoaded;

   rvCore #(.resetAddr(32'd0), .addrWidth(24)) rvCore_inst (
      .clk    (clk),
      .reset  (reset),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // Byte enables widened to bit enables
   function automatic wordT laneBits(input logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   function automatic int busyCycles();
      return stretchOn ? int'($urandom % 4) : 0;  // 0 to 3 stall cycles
   endfunction

   task automatic loadStim();
      int         fd;
      int         n;
      string      line;
      wordT       a;
      wordT       d;
      logic [3:0] m;
      for (int i = 0; i < memDepth; i++) begin
         image[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);  // Fill depends on address
      end
      numP = 0;
      fd   = $fopen("testbench/progStim.mem", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.substr(0, 0) == "P") begin
               n = $sscanf(line, "P %h %h", a, d);
               image[a[9:2]] = d;
               numP++;
            end else if (n > 0 && line.substr(0, 0) == "E") begin
               n = $sscanf(line, "E %h %h %h", a, d, m);
               expAddr.push_back(a);
               expData.push_back(d);
               expMask.push_back(m);
            end
         end
         $fclose(fd);
      end
      stimLoaded = 1'b1;
   endtask

   // ****************************************
   // Memory model, answers one cycle after the strobe
   // ****************************************
   always @(negedge clk) reqSeen = memReq;

   always @(posedge clk) begin
      #1;
      if (!reset) begin
         rCnt   = 0;
         wCnt   = 0;
         memRsp = '0;
      end else begin
         if (rCnt != 0) rCnt--;
         if (wCnt != 0) wCnt--;
         if (reqSeen.rstrb) begin
            memRsp.rdata = mem[reqSeen.addr[9:2]];
            rCnt         = busyCycles();
         end
         if (reqSeen.wmask != 4'b0000) begin
            if (expIdx >= expAddr.size()) begin
               $display("Unexpected extra store to address %h at %0t", reqSeen.addr, $time);
               errors++;
            end else begin
               assert (reqSeen.addr == expAddr[expIdx] && reqSeen.wmask == expMask[expIdx] &&
                       (reqSeen.wdata & laneBits(reqSeen.wmask)) == expData[expIdx])
               else begin
                  $display("CHECK FAILED at %0t: store %0d addr %h expected %h/%b actual %h/%b",
                           $time, expIdx, reqSeen.addr, expData[expIdx], expMask[expIdx],
                           reqSeen.wdata & laneBits(reqSeen.wmask), reqSeen.wmask);
                  errors++;
               end
               expIdx++;
            end
            mem[reqSeen.addr[9:2]] = (mem[reqSeen.addr[9:2]] & ~laneBits(reqSeen.wmask)) |
                                     (reqSeen.wdata & laneBits(reqSeen.wmask));
            wCnt = busyCycles();
            if (reqSeen.addr == endAddr) endSeen = 1'b1;
         end
         memRsp.rbusy = (rCnt != 0);
         memRsp.wbusy = (wCnt != 0);
      end
   end

   // Watchdog, 8 cycles per instruction, x4 for busy stretching, two runs
   initial begin
      wait (stimLoaded);
      repeat (2 * (numP * 8 * 4 + 500)) @(posedge clk);
      $display("Timeout: the program never reached its end store");
      $display("Simulation finished: FAIL");
      $finish;
   end

   // ****************************************
   // Test sequence
   // ****************************************
   initial begin
      int passCount;
      int failCount;
      int errStart;
      bit testOk;
      reset     = 1'b0;
      memRsp    = '0;
      reqSeen   = '0;
      errors    = 0;
      passCount = 0;
      failCount = 0;
      errStart  = 0;
      void'($urandom(seed));
      loadStim();
      if (numP == 0) begin
         $display("Stimulus file missing or empty");
         $display("Simulation finished: FAIL");
         $finish;
      end else begin
         for (int t = 0; t < 2; t++) begin
            @(posedge clk);
            #1 reset  = 1'b0;
            stretchOn = (t == 1);  // Second run with random busy levels
            mem       = image;
            expIdx    = 0;
            endSeen   = 1'b0;
            repeat (5) @(posedge clk);
            #1 reset = 1'b1;
            wait (endSeen);
            assert (expIdx == expAddr.size())
            else begin
               $display("CHECK FAILED at %0t: store count expected %0d actual %0d",
                        $time, expAddr.size(), expIdx);
               errors++;
            end
            testOk = (errors + rvCore_inst.checker_inst.violations == errStart);
            if (testOk) passCount++;
            else failCount++;
            $display("Test %0d (%s): %s", t, stretchOn ? "busy stretching" : "no busy",
                     testOk ? "passed" : "failed");
            errStart = errors + rvCore_inst.checker_inst.violations;  // Start of next run
         end
         $display("Tests passed: %0d, failed: %0d", passCount, failCount);
         if (failCount == 0) begin
            $display("Simulation finished: PASS");
         end else begin
            $display("Simulation finished: FAIL");
         end
         $finish;
      end
   end

endmodule

/* testbench/progStim.mem */
# P <byte addr> <instruction or data word>
# E <store byte addr> <data on enabled lanes> <wmask>, in store order
P 000 10000513
P 004 FFB00093
P 008 00700113
P 00C 402081B3
P 010 00352023
P 014 0020A233
P 018 0020B2B3
P 01C 00121213
P 020 00526233
P 024 00452223
P 028 01F0D313
P 02C 4010D393
P 030 0063C3B3
P 034 0003D3B3
P 038 00752423
P 03C 00000593
P 040 00500613
P 044 00358593
P 048 FFF60613
P 04C FE061CE3
P 050 00208463
P 054 00158593
P 058 0020C463
P 05C 04058593
P 060 0020F463
P 064 04058593
P 068 00115463
P 06C 04058593
P 070 0020E463
P 074 00158593
P 078 00B52623
P 07C 123456B7
P 080 0080076F
P 084 00000693
P 088 00001797
P 08C 01070867
P 090 00000693
P 094 00D52823
P 098 00F52A23
P 09C 40E80833
P 0A0 01052C23
P 0A4 04350A03
P 0A8 04154A83
P 0AC 04251B03
P 0B0 04055B83
P 0B4 054508A3
P 0B8 05651923
P 0BC 010A9A93
P 0C0 017AEAB3
P 0C4 05552A23
P 0C8 00500013
P 0CC 04052C23
P 0D0 00100C93
P 0D4 0F952E23
P 0D8 0000006F
P 140 80FFF701
E 100 FFFFFFF4 F
E 104 00000002 F
E 108 FFFFFFFC F
E 10C 00000011 F
E 110 12345000 F
E 114 00001088 F
E 118 0000000C F
E 151 00008000 2
E 152 80FF0000 C
E 154 00F7F701 F
E 158 00000000 F
E 1FC 00000001 F

/* verilog.f */
rtl/rvIsaPkg.sv
rtl/rvCorePkg.sv
rtl/rvAlu.sv
rtl/rvAddrUnit.sv
rtl/rvRegFile.sv
rtl/rvControl.sv
rtl/rvCore.sv
testbench/rvCore_checker.sv
testbench/rvCoreTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the rvCore testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module rvCoreTb -o simRvCore

./obj_dir/simRvCore | tee sim.log

grep -q "Simulation finished: PASS" sim.log
echo "rvCore simulation passed"
